// ==== Bender.yml ====
package:
  name: dsp_core

sources:
  # rtl
  - files:
      - rtl/dsp_cfg_pkg.sv
      - rtl/dsp_isa_pkg.sv
      - rtl/block_sequencer.sv
      - rtl/madd_unit.sv
      - rtl/misc_unit.sv
      - rtl/channel_writeback.sv
      - rtl/dsp_core.sv
  # dv
  - target: simulation
    files:
      - dv/dsp_core_chk.sv
      - dv/dsp_core_tb.sv

// ==== dv/dsp_core_chk.sv ====
`default_nettype none

module dsp_core_chk (
	input wire clk,
	input wire reset,
	input wire ready,
	input wire issue_madd,
	input wire issue_misc,
	input wire madd_valid,
	input wire misc_valid,
	input wire wb_done
);
	timeunit 1ns;
	timeprecision 100ps;

	// a new issue never overlaps the results of the previous block
	a_one_issue: assert property (@(posedge clk) disable iff (reset)
		(issue_madd || issue_misc) |->
			!(issue_madd && issue_misc) && !madd_valid && !misc_valid && !wb_done)
		else $error("issue on both units or over a result still in flight");

	a_one_valid: assert property (@(posedge clk) disable iff (reset)
		!(madd_valid && misc_valid)) else $error("madd_valid and misc_valid high together");

	// writeback only happens inside a walk
	a_done_busy: assert property (@(posedge clk) disable iff (reset)
		!(wb_done && ready)) else $error("wb_done high while ready is high");

	a_ready_after_reset: assert property (@(posedge clk) $fell(reset) |-> ready)
		else $error("ready low in the first cycle after reset");
endmodule

bind dsp_core dsp_core_chk i_chk (.*);

`default_nettype wire

// ==== dv/dsp_core_tb.sv ====
`default_nettype none

module dsp_core_tb
	import dsp_cfg_pkg::*;
	import dsp_isa_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES  = 5;
	localparam int PROGS         = 3;  // programs per single-unit test
	localparam int MIX_PROGS     = 2;
	localparam int SHORT_TICKS   = 10;
	localparam int LONG_TICKS    = 20;
	localparam int N_RAND_WRITES = 20;
	localparam int N_TICKS  = 4 + 2 * PROGS * SHORT_TICKS + MIX_PROGS * LONG_TICKS;
	localparam int N_WRITES = N_RAND_WRITES + (2 * PROGS + MIX_PROGS) * N_BLOCKS;
	localparam int N_RESETS = 2 + 2 * PROGS + MIX_PROGS;
	localparam int CYCLE_LIMIT = N_TICKS * (4 * N_BLOCKS + 8) + 2 * N_WRITES
		+ N_RESETS * (RESET_CYCLES + 2);
	localparam int MODE_MADD = 0;
	localparam int MODE_MISC = 1;
	localparam int MODE_MIX  = 2;

	logic                     clk;
	logic                     reset;
	logic                     tick;
	logic signed [DATA_W-1:0] sample_in;
	logic signed [DATA_W-1:0] sample_out;
	logic                     instr_write;
	logic [BLK_ADDR_W-1:0]    instr_addr;
	instr_u                   instr_data;
	logic                     ready;
	logic [BLK_CNT_W-1:0]     n_blocks_running;

	instr_u                   model_store [N_BLOCKS];
	logic signed [DATA_W-1:0] model_ch [N_CHANNELS];
	logic [BLK_CNT_W-1:0]     model_count;
	logic [31:0]              rng_state = 32'd91463;
	int                       cycles;
	int                       tests;
	int                       checks;
	int                       errors;
	int                       test_errors;

	dsp_core i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	// biased toward the saturation corners
	function automatic logic signed [DATA_W-1:0] rand_data();
		logic [31:0] r;
		r = next_rand();
		case (r[2:0])
			3'd0:    return SAT_MAX;
			3'd1:    return SAT_MIN;
			3'd2:    return -16'sd1;
			default: return r[31:16];
		endcase
	endfunction

	function automatic instr_u rand_instr(input int mode);
		instr_u      w;
		logic [31:0] r;
		r = next_rand();
		w = next_rand();
		if (mode == MODE_MISC || (mode == MODE_MIX && r[0])) begin
			w.misc.kind = KIND_MISC;
			w.misc.imm  = rand_data();
		end else if (mode == MODE_MADD && r[2:1] == 2'd0) begin
			w.misc.kind    = KIND_MISC; // constant load to feed the multiplier
			w.misc.misc_op = MISC_MOV_IMM;
			w.misc.imm     = rand_data();
		end else begin
			w.madd.kind = KIND_MADD;
		end
		return w;
	endfunction

	function automatic logic signed [DATA_W-1:0] model_madd(input instr_u w);
		int a;
		int b;
		int c;
		int sum;
		a = model_ch[w.madd.src_a];
		b = model_ch[w.madd.src_b];
		c = model_ch[w.madd.src_c];
		sum = a * b + (c <<< w.madd.shift);
		sum = sum >>> w.madd.shift;
		if (w.madd.sat_disable)
			return sum[DATA_W-1:0];
		return (sum > SAT_MAX) ? SAT_MAX : (sum < SAT_MIN) ? SAT_MIN : sum[DATA_W-1:0];
	endfunction

	function automatic logic signed [DATA_W-1:0] model_misc(input instr_u w);
		int a;
		int b;
		int s;
		a = model_ch[w.misc.src_a];
		b = model_ch[w.misc.src_b];
		s = a + b;
		case (w.misc.misc_op)
			MISC_MOV_IMM: return w.misc.imm;
			MISC_ADD_SAT: return (s > SAT_MAX) ? SAT_MAX : (s < SAT_MIN) ? SAT_MIN : DATA_W'(s);
			MISC_MIN:     return DATA_W'((a < b) ? a : b);
			MISC_MAX:     return DATA_W'((a > b) ? a : b);
			MISC_ABS:     return (a == SAT_MIN) ? SAT_MAX : DATA_W'((a < 0) ? -a : a);
			default:      return DATA_W'(a);
		endcase
	endfunction

	// sample exchange first, then the blocks in address order
	task automatic model_tick(input logic signed [DATA_W-1:0] smp,
			output logic signed [DATA_W-1:0] exp_out);
		instr_u w;
		exp_out = model_ch[OUT_CH];
		model_ch[IN_CH] = smp;
		for (int i = 0; i < model_count; i++) begin
			w = model_store[i];
			if (w.madd.kind == KIND_MADD)
				model_ch[w.madd.dest] = model_madd(w);
			else
				model_ch[w.misc.dest] = model_misc(w);
		end
	endtask

	task automatic check_sample(input string name, input logic signed [DATA_W-1:0] exp_val,
			input logic signed [DATA_W-1:0] act_val);
		checks++;
		if (act_val !== exp_val) begin
			test_errors++;
			$display("mismatch %s expected %0d actual %0d", name, exp_val, act_val);
		end
	endtask

	task automatic check_count(input string name, input logic [BLK_CNT_W-1:0] exp_val,
			input logic [BLK_CNT_W-1:0] act_val);
		checks++;
		if (act_val !== exp_val) begin
			test_errors++;
			$display("mismatch %s expected %0d actual %0d", name, exp_val, act_val);
		end
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		reset       = 1'b0;
		model_count = '0;
		foreach (model_ch[i])
			model_ch[i] = '0;
	endtask

	task automatic write_instr(input string name, input logic [BLK_ADDR_W-1:0] addr,
			input instr_u w);
		int next_count;
		instr_write = 1'b1;
		instr_addr  = addr;
		instr_data  = w;
		@(posedge clk);
		#2;
		instr_write = 1'b0;
		model_store[addr] = w;
		next_count = int'(addr) + 1;
		if (next_count >= int'(model_count))
			model_count = BLK_CNT_W'(next_count);
		check_count(name, model_count, n_blocks_running);
	endtask

	task automatic do_tick(input string name, input logic signed [DATA_W-1:0] smp);
		logic signed [DATA_W-1:0] exp_out;
		tick      = 1'b1;
		sample_in = smp;
		@(posedge clk);
		#2;
		tick = 1'b0;
		model_tick(smp, exp_out);
		check_sample(name, exp_out, sample_out);
		while (ready !== 1'b1) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic run_program(input string name, input int mode, input int n_ticks);
		int     len;
		instr_u w;
		apply_reset();
		len = 1 + next_rand() % N_BLOCKS;
		for (int a = len - 1; a >= 0; a--) begin // top address first, then lower ones
			w = rand_instr(mode);
			if (a == len - 1)
				w.madd.dest = OUT_CH;
			write_instr(name, BLK_ADDR_W'(a), w);
		end
		repeat (n_ticks) do_tick(name, rand_data());
	endtask

	task automatic finish_test(input string name);
		tests++;
		errors += test_errors;
		if (test_errors == 0)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, test_errors);
		test_errors = 0;
	endtask

	initial begin
		reset       = 1'b1;
		tick        = 1'b0;
		sample_in   = '0;
		instr_write = 1'b0;
		instr_addr  = '0;
		instr_data  = '0;
		tests       = 0;
		checks      = 0;
		errors      = 0;
		test_errors = 0;
		@(posedge clk);
		#2;

		apply_reset();
		check_count("reset_idle", '0, n_blocks_running);
		if (ready !== 1'b1) begin
			test_errors++;
			$display("reset_idle: ready is not high after reset");
		end
		repeat (4) do_tick("reset_idle", rand_data());
		finish_test("reset_idle");

		apply_reset();
		repeat (N_RAND_WRITES)
			write_instr("write_count", BLK_ADDR_W'(next_rand()), rand_instr(MODE_MIX));
		finish_test("write_count");

		repeat (PROGS) run_program("madd_prog", MODE_MADD, SHORT_TICKS);
		finish_test("madd_prog");
		repeat (PROGS) run_program("misc_prog", MODE_MISC, SHORT_TICKS);
		finish_test("misc_prog");
		repeat (MIX_PROGS) run_program("mixed_prog", MODE_MIX, LONG_TICKS);
		finish_test("mixed_prog");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: ready never returned");
		$display("TB FAILED");
		$finish;
	end
endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/dsp_cfg_pkg.sv
rtl/dsp_isa_pkg.sv
rtl/block_sequencer.sv
rtl/madd_unit.sv
rtl/misc_unit.sv
rtl/channel_writeback.sv
rtl/dsp_core.sv
dv/dsp_core_chk.sv
dv/dsp_core_tb.sv

// ==== rtl/block_sequencer.sv ====
`default_nettype none

module block_sequencer
	import dsp_cfg_pkg::*;
	import dsp_isa_pkg::*;
(
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   tick,
	input  wire                   instr_write,
	input  wire  [BLK_ADDR_W-1:0] instr_addr,
	input  wire  instr_u          instr_data,
	input  wire                   wb_done,
	output logic                  ready,
	output logic [BLK_CNT_W-1:0]  n_blocks_running,
	output logic                  issue_madd,
	output logic                  issue_misc,
	output instr_u                cur_instr,
	output logic [CH_ADDR_W-1:0]  rd_addr_a,
	output logic [CH_ADDR_W-1:0]  rd_addr_b,
	output logic [CH_ADDR_W-1:0]  rd_addr_c,
	output logic [CH_ADDR_W-1:0]  wb_dest
);
	instr_u                store [N_BLOCKS];
	logic [BLK_ADDR_W-1:0] blk;        // block in flight
	logic                  issuing;    // issue cycle of the current block
	logic [BLK_CNT_W-1:0]  blk_next;
	logic [BLK_CNT_W-1:0]  wr_count;
	logic                  start;
	logic                  advance;
	logic [BLK_ADDR_W-1:0] fetch_addr;

	assign wr_count   = BLK_CNT_W'(instr_addr) + BLK_CNT_W'(1);
	assign blk_next   = BLK_CNT_W'(blk) + BLK_CNT_W'(1);
	assign start      = ready && tick && (n_blocks_running != '0);
	assign advance    = !ready && !issuing && wb_done && (blk_next != n_blocks_running);
	assign fetch_addr = start ? '0 : blk_next[BLK_ADDR_W-1:0];

	always_ff @(posedge clk) begin
		if (instr_write)
			store[instr_addr] <= instr_data;
	end

	// count only grows, to one past the highest address written
	always_ff @(posedge clk) begin
		if (reset)
			n_blocks_running <= '0;
		else if (instr_write && wr_count >= n_blocks_running)
			n_blocks_running <= wr_count;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ready   <= 1'b1;
			issuing <= 1'b0;
			blk     <= '0;
		end else if (start) begin
			ready   <= 1'b0;
			issuing <= 1'b1;
			blk     <= '0;
		end else if (issuing) begin
			issuing <= 1'b0;
		end else if (advance) begin
			issuing <= 1'b1;
			blk     <= blk_next[BLK_ADDR_W-1:0];
		end else if (!ready && wb_done) begin
			ready <= 1'b1; // last block written back
		end
	end

	always_ff @(posedge clk) begin
		if (start || advance)
			cur_instr <= store[fetch_addr];
	end

	assign issue_madd = issuing && (cur_instr.madd.kind == KIND_MADD);
	assign issue_misc = issuing && (cur_instr.madd.kind == KIND_MISC);

	// register fields sit at the same place in both formats
	assign rd_addr_a = cur_instr.madd.src_a;
	assign rd_addr_b = cur_instr.madd.src_b;
	assign rd_addr_c = cur_instr.madd.src_c;
	assign wb_dest   = cur_instr.madd.dest;
endmodule

`default_nettype wire

// ==== rtl/channel_writeback.sv ====
`default_nettype none

module channel_writeback
	import dsp_cfg_pkg::*;
(
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        tick,
	input  wire  signed [DATA_W-1:0]   sample_in,
	input  wire         [CH_ADDR_W-1:0] rd_addr_a,
	input  wire         [CH_ADDR_W-1:0] rd_addr_b,
	input  wire         [CH_ADDR_W-1:0] rd_addr_c,
	input  wire         [CH_ADDR_W-1:0] wb_dest,
	input  wire                        madd_valid,
	input  wire  signed [DATA_W-1:0]   madd_result,
	input  wire                        misc_valid,
	input  wire  signed [DATA_W-1:0]   misc_result,
	output logic signed [DATA_W-1:0]   op_a,
	output logic signed [DATA_W-1:0]   op_b,
	output logic signed [DATA_W-1:0]   op_c,
	output logic signed [DATA_W-1:0]   sample_out,
	output logic                       wb_done
);
	logic signed [DATA_W-1:0] channels [N_CHANNELS];
	logic                     wb_en;
	logic signed [DATA_W-1:0] wb_val;

	assign op_a = channels[rd_addr_a];
	assign op_b = channels[rd_addr_b];
	assign op_c = channels[rd_addr_c];

	// only one block in flight, so at most one unit finishes per cycle
	assign wb_en  = madd_valid || misc_valid;
	assign wb_val = madd_valid ? madd_result : misc_result;

	always_ff @(posedge clk) begin
		if (reset) begin
			channels   <= '{default: '0};
			sample_out <= '0;
			wb_done    <= 1'b0;
		end else begin
			wb_done <= wb_en;
			if (wb_en)
				channels[wb_dest] <= wb_val;

			// sample exchange takes priority over a result aimed at IN_CH
			if (tick) begin
				channels[IN_CH] <= sample_in;
				sample_out      <= channels[OUT_CH]; // value from before this edge
			end
		end
	end
endmodule

`default_nettype wire

// ==== rtl/dsp_cfg_pkg.sv ====
`default_nettype none

package dsp_cfg_pkg;
	localparam int DATA_W     = 16;
	localparam int PROD_W     = 2 * DATA_W; // multiply-add internal width
	localparam int N_CHANNELS = 16;
	localparam int CH_ADDR_W  = 4;
	localparam int N_BLOCKS   = 16;
	localparam int BLK_ADDR_W = 4;
	localparam int BLK_CNT_W  = 5;          // holds 0..N_BLOCKS

	localparam logic [CH_ADDR_W-1:0] IN_CH  = CH_ADDR_W'(0);
	localparam logic [CH_ADDR_W-1:0] OUT_CH = CH_ADDR_W'(1);

	localparam logic signed [DATA_W-1:0] SAT_MAX = {1'b0, {(DATA_W - 1){1'b1}}};
	localparam logic signed [DATA_W-1:0] SAT_MIN = {1'b1, {(DATA_W - 1){1'b0}}};
endpackage

`default_nettype wire

// ==== rtl/dsp_core.sv ====
`default_nettype none

module dsp_core
	import dsp_cfg_pkg::*;
	import dsp_isa_pkg::*;
(
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       tick,
	input  wire  signed [DATA_W-1:0]  sample_in,
	output logic signed [DATA_W-1:0]  sample_out,
	input  wire                       instr_write,
	input  wire  [BLK_ADDR_W-1:0]     instr_addr,
	input  wire  instr_u              instr_data,
	output logic                      ready,
	output logic [BLK_CNT_W-1:0]      n_blocks_running
);
	instr_u                   cur_instr;
	logic                     issue_madd;
	logic                     issue_misc;
	logic [CH_ADDR_W-1:0]     rd_addr_a;
	logic [CH_ADDR_W-1:0]     rd_addr_b;
	logic [CH_ADDR_W-1:0]     rd_addr_c;
	logic [CH_ADDR_W-1:0]     wb_dest;
	logic                     wb_done;
	logic signed [DATA_W-1:0] op_a;
	logic signed [DATA_W-1:0] op_b;
	logic signed [DATA_W-1:0] op_c;
	logic                     madd_valid;
	logic signed [DATA_W-1:0] madd_result;
	logic                     misc_valid;
	logic signed [DATA_W-1:0] misc_result;

	block_sequencer i_sequencer (
		.clk              (clk),
		.reset            (reset),
		.tick             (tick),
		.instr_write      (instr_write),
		.instr_addr       (instr_addr),
		.instr_data       (instr_data),
		.wb_done          (wb_done),
		.ready            (ready),
		.n_blocks_running (n_blocks_running),
		.issue_madd       (issue_madd),
		.issue_misc       (issue_misc),
		.cur_instr        (cur_instr),
		.rd_addr_a        (rd_addr_a),
		.rd_addr_b        (rd_addr_b),
		.rd_addr_c        (rd_addr_c),
		.wb_dest          (wb_dest)
	);

	madd_unit i_madd (
		.clk         (clk),
		.reset       (reset),
		.issue_madd  (issue_madd),
		.op_a        (op_a),
		.op_b        (op_b),
		.op_c        (op_c),
		.shift       (cur_instr.madd.shift),
		.sat_disable (cur_instr.madd.sat_disable),
		.madd_valid  (madd_valid),
		.madd_result (madd_result)
	);

	misc_unit i_misc (
		.clk         (clk),
		.reset       (reset),
		.issue_misc  (issue_misc),
		.cur_instr   (cur_instr),
		.op_a        (op_a),
		.op_b        (op_b),
		.misc_valid  (misc_valid),
		.misc_result (misc_result)
	);

	channel_writeback i_writeback (
		.clk         (clk),
		.reset       (reset),
		.tick        (tick),
		.sample_in   (sample_in),
		.rd_addr_a   (rd_addr_a),
		.rd_addr_b   (rd_addr_b),
		.rd_addr_c   (rd_addr_c),
		.wb_dest     (wb_dest),
		.madd_valid  (madd_valid),
		.madd_result (madd_result),
		.misc_valid  (misc_valid),
		.misc_result (misc_result),
		.op_a        (op_a),
		.op_b        (op_b),
		.op_c        (op_c),
		.sample_out  (sample_out),
		.wb_done     (wb_done)
	);
endmodule

`default_nettype wire

// ==== rtl/dsp_isa_pkg.sv ====
`default_nettype none

package dsp_isa_pkg;
	import dsp_cfg_pkg::*;

	localparam int INSTR_W   = 32;
	localparam int SHIFT_W   = 4;
	localparam int MISC_OP_W = 3;

	localparam logic KIND_MADD = 1'b0;
	localparam logic KIND_MISC = 1'b1;

	// codes 5..7 pass operand a through
	localparam logic [MISC_OP_W-1:0] MISC_MOV_IMM = 3'd0;
	localparam logic [MISC_OP_W-1:0] MISC_ADD_SAT = 3'd1;
	localparam logic [MISC_OP_W-1:0] MISC_MIN     = 3'd2;
	localparam logic [MISC_OP_W-1:0] MISC_MAX     = 3'd3;
	localparam logic [MISC_OP_W-1:0] MISC_ABS     = 3'd4;

	typedef struct packed {
		logic                                         kind;
		logic [CH_ADDR_W-1:0]                         dest;
		logic [CH_ADDR_W-1:0]                         src_a;
		logic [CH_ADDR_W-1:0]                         src_b;
		logic [CH_ADDR_W-1:0]                         src_c;
		logic [SHIFT_W-1:0]                           shift;
		logic                                         sat_disable;
		logic [INSTR_W-4*CH_ADDR_W-SHIFT_W-3:0]       unused;
	} madd_fmt_t;

	typedef struct packed {
		logic                     kind;
		logic [CH_ADDR_W-1:0]     dest;
		logic [CH_ADDR_W-1:0]     src_a;
		logic [CH_ADDR_W-1:0]     src_b;
		logic [MISC_OP_W-1:0]     misc_op;
		logic signed [DATA_W-1:0] imm;
	} misc_fmt_t;

	typedef union packed {
		madd_fmt_t madd;
		misc_fmt_t misc;
	} instr_u;
endpackage

`default_nettype wire

// ==== rtl/madd_unit.sv ====
`default_nettype none

module madd_unit
	import dsp_cfg_pkg::*;
	import dsp_isa_pkg::*;
(
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       issue_madd,
	input  wire  signed [DATA_W-1:0]  op_a,
	input  wire  signed [DATA_W-1:0]  op_b,
	input  wire  signed [DATA_W-1:0]  op_c,
	input  wire         [SHIFT_W-1:0] shift,
	input  wire                       sat_disable,
	output logic                      madd_valid,
	output logic signed [DATA_W-1:0]  madd_result
);
	logic signed [PROD_W-1:0]  prod_q;
	logic signed [PROD_W-1:0]  addend_q;
	logic        [SHIFT_W-1:0] shift_q;
	logic                      sat_disable_q;
	logic                      stage1_valid;
	logic signed [PROD_W-1:0]  sum;
	logic signed [PROD_W-1:0]  scaled;
	logic signed [DATA_W-1:0]  clipped;

	always_ff @(posedge clk) begin
		prod_q        <= op_a * op_b;
		addend_q      <= PROD_W'(op_c) <<< shift; // c lined up with the product scale
		shift_q       <= shift;
		sat_disable_q <= sat_disable;
	end

	assign sum    = prod_q + addend_q;
	assign scaled = sum >>> shift_q;

	always_comb begin
		if (sat_disable_q)
			clipped = scaled[DATA_W-1:0]; // wrap
		else if (scaled > SAT_MAX)
			clipped = SAT_MAX;
		else if (scaled < SAT_MIN)
			clipped = SAT_MIN;
		else
			clipped = scaled[DATA_W-1:0];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			stage1_valid <= 1'b0;
			madd_valid   <= 1'b0;
		end else begin
			stage1_valid <= issue_madd;
			madd_valid   <= stage1_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (stage1_valid)
			madd_result <= clipped;
	end
endmodule

`default_nettype wire

// ==== rtl/misc_unit.sv ====
`default_nettype none

module misc_unit
	import dsp_cfg_pkg::*;
	import dsp_isa_pkg::*;
(
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       issue_misc,
	input  wire  instr_u              cur_instr,
	input  wire  signed [DATA_W-1:0]  op_a,
	input  wire  signed [DATA_W-1:0]  op_b,
	output logic                      misc_valid,
	output logic signed [DATA_W-1:0]  misc_result
);
	logic        [MISC_OP_W-1:0] misc_op;
	logic signed [DATA_W-1:0]    imm;
	logic signed [DATA_W:0]      wide_sum; // one guard bit
	logic signed [DATA_W-1:0]    sat_sum;
	logic signed [DATA_W-1:0]    abs_a;
	logic signed [DATA_W-1:0]    result;

	assign misc_op  = cur_instr.misc.misc_op;
	assign imm      = cur_instr.misc.imm;
	assign wide_sum = op_a + op_b;

	assign sat_sum = (wide_sum > SAT_MAX) ? SAT_MAX :
		(wide_sum < SAT_MIN) ? SAT_MIN : wide_sum[DATA_W-1:0];

	// most negative value has no positive twin
	assign abs_a = (op_a == SAT_MIN) ? SAT_MAX :
		op_a[DATA_W-1] ? -op_a : op_a;

	always_comb begin
		case (misc_op)
			MISC_MOV_IMM: result = imm;
			MISC_ADD_SAT: result = sat_sum;
			MISC_MIN:     result = (op_a < op_b) ? op_a : op_b;
			MISC_MAX:     result = (op_a > op_b) ? op_a : op_b;
			MISC_ABS:     result = abs_a;
			default:      result = op_a;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			misc_valid <= 1'b0;
		else
			misc_valid <= issue_misc;
	end

	always_ff @(posedge clk) begin
		if (issue_misc)
			misc_result <= result;
	end
endmodule

`default_nettype wire
